// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dehaze_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard src/*.sv) $(wildcard tests/*.sv)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) files.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f files.f

run: $(BIN) tests/dehaze_stim.txt
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
src/dehaze_pkg.sv
src/frame_rd_if.sv
src/frame_store.sv
src/dark_channel.sv
src/scene_recovery.sv
src/dehaze_top.sv
tests/dehaze_tb.sv

// ==== src/dark_channel.sv ====
`timescale 1ns/1ps

module dark_channel (
    input  logic              clk,
    input  logic              rst,
    input  logic              full_req,
    output logic              full_ack,
    frame_rd_if.reader        win_rd,
    output logic              map_req,
    input  logic              map_ack,
    input  dehaze_pkg::addr_t dark_addr,
    output dehaze_pkg::chan_t dark
);
    import dehaze_pkg::*;

    localparam coord_t first_pos = coord_t'(1);
    localparam coord_t last_pos  = coord_t'(img_dim - 2);

    chan_t  dark_map [num_pix];
    coord_t scan_x;
    coord_t scan_y;
    logic   scanning;
    chan_t  dark_min;

    function automatic chan_t min2(chan_t a, chan_t b);
        return (a < b) ? a : b;
    endfunction

    // 27 channel values of the current window
    always_comb begin
        dark_min = '1;
        for (int k = 0; k < 9; k++) begin
            dark_min = min2(dark_min, min2(win_rd.taps[k].r,
                                           min2(win_rd.taps[k].g, win_rd.taps[k].b)));
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scanning <= 1'b0;
            scan_x   <= first_pos;
            scan_y   <= first_pos;
            map_req  <= 1'b0;
            full_ack <= 1'b0;
        end else begin
            if (scanning) begin
                if (scan_x == last_pos) begin
                    scan_x <= first_pos;
                    if (scan_y == last_pos) begin
                        scan_y   <= first_pos;
                        scanning <= 1'b0;
                        map_req  <= 1'b1;    // last window written this edge
                    end else begin
                        scan_y <= scan_y + 1'b1;
                    end
                end else begin
                    scan_x <= scan_x + 1'b1;
                end
            end else if (full_req && !full_ack && !map_req && !map_ack) begin
                scanning <= 1'b1;
            end

            // output stage done with the frame, let the store go
            if (map_req && map_ack) begin
                full_ack <= 1'b1;
            end
            if (full_ack && !full_req) begin
                full_ack <= 1'b0;
                map_req  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (scanning) begin
            dark_map[{scan_y, scan_x}] <= dark_min;
        end
    end

    assign win_rd.win_x = scan_x;
    assign win_rd.win_y = scan_y;
    assign dark         = dark_map[dark_addr];

    // window centre as seen through the interface
    a_scan_interior: assert property (
        @(posedge clk) disable iff (rst)
        scanning |-> win_rd.win_x inside {[first_pos:last_pos]}
                  && win_rd.win_y inside {[first_pos:last_pos]}
    );

endmodule

// ==== src/dehaze_pkg.sv ====
package dehaze_pkg;

    localparam int img_dim = 8;
    localparam int num_pix = img_dim * img_dim;

    typedef logic [2:0] coord_t;
    typedef logic [5:0] addr_t;    // {y, x}
    typedef logic [7:0] chan_t;

    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } rgb_t;

    // 3x3 neighbourhood, index 0 is top left, raster order
    typedef rgb_t [8:0] win_t;

    typedef logic [6:0] gain_t;    // Q4, 64 down to 16
    typedef gain_t [255:0] gain_tbl_t;

    // t_pct = 25 + 0.3 * dark, capped at 100
    // gain = 1 / t in Q4
    function automatic gain_tbl_t make_gain_rom();
        gain_tbl_t tbl;
        int t_pct;
        for (int d = 0; d < 256; d++) begin
            t_pct = 25 + (3 * d) / 10;
            if (t_pct > 100) begin
                t_pct = 100;
            end
            tbl[d] = gain_t'(1600 / t_pct);
        end
        return tbl;
    endfunction

    localparam gain_tbl_t gain_rom = make_gain_rom();

endpackage

// ==== src/dehaze_top.sv ====
`timescale 1ns/1ps

module dehaze_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_req,
    output logic             in_ack,
    input  dehaze_pkg::rgb_t in_pix,
    output logic             out_req,
    input  logic             out_ack,
    output dehaze_pkg::rgb_t out_pix,
    output logic             out_last
);
    import dehaze_pkg::*;

    logic  full_req;
    logic  full_ack;
    logic  map_req;
    logic  map_ack;
    addr_t dark_addr;
    chan_t dark;

    frame_rd_if win_rd ();    // window taps for the dark channel scan
    frame_rd_if pix_rd ();    // center pixel for output

    frame_store u_store (
        .clk      (clk),
        .rst      (rst),
        .in_req   (in_req),
        .in_ack   (in_ack),
        .in_pix   (in_pix),
        .full_req (full_req),
        .full_ack (full_ack),
        .win_rd   (win_rd.store),
        .pix_rd   (pix_rd.store)
    );

    dark_channel u_dark (
        .clk       (clk),
        .rst       (rst),
        .full_req  (full_req),
        .full_ack  (full_ack),
        .win_rd    (win_rd.reader),
        .map_req   (map_req),
        .map_ack   (map_ack),
        .dark_addr (dark_addr),
        .dark      (dark)
    );

    scene_recovery u_recover (
        .clk       (clk),
        .rst       (rst),
        .map_req   (map_req),
        .map_ack   (map_ack),
        .pix_rd    (pix_rd.reader),
        .dark_addr (dark_addr),
        .dark      (dark),
        .out_req   (out_req),
        .out_ack   (out_ack),
        .out_pix   (out_pix),
        .out_last  (out_last)
    );

endmodule

// ==== src/frame_rd_if.sv ====
`timescale 1ns/1ps

interface frame_rd_if;
    import dehaze_pkg::*;

    coord_t win_x;
    coord_t win_y;
    win_t   taps;     // neighbourhood around (win_x, win_y)
    rgb_t   center;

    modport reader (
        output win_x,
        output win_y,
        input  taps,
        input  center
    );

    // combinational lookup on the store side
    modport store (
        input  win_x,
        input  win_y,
        output taps,
        output center
    );

endinterface

// ==== src/frame_store.sv ====
`timescale 1ns/1ps

module frame_store (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_req,
    output logic             in_ack,
    input  dehaze_pkg::rgb_t in_pix,
    output logic             full_req,
    input  logic             full_ack,
    frame_rd_if.store        win_rd,
    frame_rd_if.store        pix_rd
);
    import dehaze_pkg::*;

    rgb_t  mem [num_pix];
    addr_t wr_addr;
    logic  wr_en;

    // wraps at the image edge, callers only care about interior windows
    function automatic addr_t tap_addr(coord_t x, coord_t y, int k);
        coord_t tx;
        coord_t ty;
        tx = x + coord_t'(k % 3) - coord_t'(1);
        ty = y + coord_t'(k / 3) - coord_t'(1);
        return {ty, tx};
    endfunction

    // new pixel only once the previous ack is back low
    assign wr_en = in_req && !in_ack && !full_req;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_ack   <= 1'b0;
            wr_addr  <= '0;
            full_req <= 1'b0;
        end else begin
            if (wr_en) begin
                in_ack  <= 1'b1;
                wr_addr <= wr_addr + 1'b1;    // rolls back to 0 after the last pixel
                if (wr_addr == addr_t'(num_pix - 1)) begin
                    full_req <= 1'b1;
                end
            end else if (in_ack && !in_req) begin
                in_ack <= 1'b0;
            end

            // frame released downstream
            if (full_req && full_ack) begin
                full_req <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= in_pix;
        end
    end

    for (genvar k = 0; k < 9; k++) begin : g_tap
        assign win_rd.taps[k] = mem[tap_addr(win_rd.win_x, win_rd.win_y, k)];
        assign pix_rd.taps[k] = mem[tap_addr(pix_rd.win_x, pix_rd.win_y, k)];
    end

    assign win_rd.center = mem[{win_rd.win_y, win_rd.win_x}];
    assign pix_rd.center = mem[{pix_rd.win_y, pix_rd.win_x}];

    // a write edge never follows a cycle with the frame held
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (rst)
        $rose(in_ack) |-> !$past(full_req)
    );

endmodule

// ==== src/scene_recovery.sv ====
`timescale 1ns/1ps

module scene_recovery (
    input  logic              clk,
    input  logic              rst,
    input  logic              map_req,
    output logic              map_ack,
    frame_rd_if.reader        pix_rd,
    output dehaze_pkg::addr_t dark_addr,
    input  dehaze_pkg::chan_t dark,
    output logic              out_req,
    input  logic              out_ack,
    output dehaze_pkg::rgb_t  out_pix,
    output logic              out_last
);
    import dehaze_pkg::*;

    localparam coord_t edge_pos = coord_t'(img_dim - 1);

    addr_t  pix_addr;
    logic   streaming;
    coord_t pos_x;
    coord_t pos_y;
    logic   border;
    gain_t  gain;
    rgb_t   rec_pix;

    // J = A - min(A, gain * (A - I)), A = 255
    function automatic chan_t recover(chan_t c, gain_t g);
        chan_t       inv;
        logic [14:0] prod;
        logic [10:0] scaled;
        inv    = 8'd255 - c;
        prod   = g * inv;
        scaled = prod[14:4];
        return (scaled > 11'd255) ? 8'd0 : 8'd255 - scaled[7:0];
    endfunction

    assign pos_x     = pix_addr[2:0];
    assign pos_y     = pix_addr[5:3];
    assign dark_addr = pix_addr;

    assign pix_rd.win_x = pos_x;
    assign pix_rd.win_y = pos_y;

    assign border = (pos_x == '0) || (pos_y == '0) || (pos_x == edge_pos) || (pos_y == edge_pos);
    assign gain   = gain_rom[dark];

    always_comb begin
        if (border) begin
            rec_pix = pix_rd.center;    // untouched
        end else begin
            rec_pix.r = recover(pix_rd.center.r, gain);
            rec_pix.g = recover(pix_rd.center.g, gain);
            rec_pix.b = recover(pix_rd.center.b, gain);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            streaming <= 1'b0;
            pix_addr  <= '0;
            out_req   <= 1'b0;
            out_last  <= 1'b0;
            map_ack   <= 1'b0;
        end else begin
            if (out_req) begin
                if (out_ack) begin
                    out_req  <= 1'b0;
                    out_last <= 1'b0;
                    pix_addr <= pix_addr + 1'b1;    // back to 0 after the frame
                    if (pix_addr == addr_t'(num_pix - 1)) begin
                        streaming <= 1'b0;
                        map_ack   <= 1'b1;
                    end
                end
            end else if (streaming && !out_ack) begin
                out_req  <= 1'b1;
                out_last <= (pix_addr == addr_t'(num_pix - 1));
            end else if (map_req && !map_ack && !streaming) begin
                streaming <= 1'b1;
            end

            if (map_ack && !map_req) begin
                map_ack <= 1'b0;
            end
        end
    end

    // payload captured together with the req edge
    always_ff @(posedge clk) begin
        if (!out_req && streaming && !out_ack) begin
            out_pix <= rec_pix;
        end
    end

    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        out_req && !out_ack |=> $stable(out_pix) && $stable(out_last)
    );

endmodule

// ==== tests/dehaze_stim.txt ====
# columns: input r g b, expected output r g b (decimal)
# one pixel per line in raster order, row 0 first
0   128 64   0   128 64
200 100 0    200 100 0
220 100 240  220 100 240
100 150 255  100 150 255
255 250 253  255 250 253
251 252 254  251 252 254
253 250 255  253 250 255
255 255 250  255 255 250
16  128 64   16  128 64
200 101 0    35  0   0
224 100 230  131 0   155
100 160 250  0   83  246
255 250 253  255 246 252
251 252 254  251 252 254
253 250 255  253 250 255
255 255 250  255 255 250
32  128 64   32  128 64
208 102 0    67  0   0
228 100 220  147 0   115
100 170 245  0   101 237
254 250 253  254 246 252
251 252 254  251 252 254
253 250 254  253 250 254
255 255 250  255 255 250
48  128 64   48  128 64
216 103 0    99  0   0
232 100 210  163 0   75
100 180 240  0   120 228
254 250 253  254 246 252
251 252 254  251 252 254
253 250 254  253 250 254
255 255 250  255 255 250
64  128 64   64  128 64
224 104 0    131 0   0
236 100 200  179 0   35
100 190 235  0   138 219
253 250 253  252 246 252
251 253 254  251 253 254
253 250 253  253 250 253
255 255 250  255 255 250
80  128 64   80  128 64
232 105 0    163 0   0
240 100 190  195 0   0
100 200 230  0   156 210
253 250 253  252 246 252
251 253 254  251 253 254
253 250 253  253 250 253
255 255 250  255 255 250
96  128 64   96  128 64
240 106 0    195 0   0
244 100 180  211 0   0
100 210 225  0   174 201
252 250 253  250 246 252
251 253 254  251 253 254
253 250 252  253 250 252
255 255 250  255 255 250
112 128 64   112 128 64
248 107 0    248 107 0
248 100 170  248 100 170
100 220 220  100 220 220
252 250 253  252 250 253
251 253 254  251 253 254
253 250 252  253 250 252
255 255 250  255 255 250

// ==== tests/dehaze_tb.sv ====
`timescale 1ns/1ps

module dehaze_tb;
    import dehaze_pkg::*;

    localparam int          clk_period      = 40;
    localparam int          drive_delay     = 2;
    localparam int          num_frames      = 2;
    localparam int          watchdog_cycles = num_frames * num_pix * 2 * 8 + 200;
    localparam logic [15:0] lfsr_seed       = 16'd56672;

    logic clk;
    logic rst;
    logic in_req;
    logic in_ack;
    rgb_t in_pix;
    logic out_req;
    logic out_ack;
    rgb_t out_pix;
    logic out_last;

    rgb_t stim_in  [num_pix];
    rgb_t stim_exp [num_pix];
    rgb_t frame1   [num_pix];    // first frame as received
    logic frame1_done;
    int   error_count;

    dehaze_top u_dut (.*);

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return state[0] ? (state >> 1) ^ 16'hb400 : state >> 1;
    endfunction

    task automatic next_edge();
        @(posedge clk);
        #(drive_delay);
    endtask

    // two bits, one step each
    task automatic draw_wait(inout logic [15:0] state, output int cycles);
        cycles = 0;
        for (int i = 0; i < 2; i++) begin
            cycles = (cycles << 1) | int'(state[0]);
            state  = lfsr_step(state);
        end
    endtask

    task automatic stop_run(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input int idx, input int exp, input int got);
        assert (got == exp) else begin
            stop_run($sformatf("[ERROR] %s at pixel %0d: expected %h, actual %h",
                               name, idx, exp, got));
        end
    endtask

    task automatic load_stim();
        int    fd;
        int    n;
        int    v [6];
        string header;
        fd = $fopen("tests/dehaze_stim.txt", "r");
        assert (fd != 0) else stop_run("could not open tests/dehaze_stim.txt");
        repeat (2) n = $fgets(header, fd);
        for (int p = 0; p < num_pix; p++) begin
            n = $fscanf(fd, "%d %d %d %d %d %d", v[0], v[1], v[2], v[3], v[4], v[5]);
            assert (n == 6) else stop_run("stim file ended early or holds a bad line");
            stim_in[p]  = {v[0][7:0], v[1][7:0], v[2][7:0]};
            stim_exp[p] = {v[3][7:0], v[4][7:0], v[5][7:0]};
        end
        $fclose(fd);
    endtask

    task automatic send_frames();
        logic [15:0] lfsr;
        int          cycles;
        lfsr = lfsr_seed;
        for (int f = 0; f < num_frames; f++) begin
            for (int p = 0; p < num_pix; p++) begin
                draw_wait(lfsr, cycles);
                repeat (cycles) next_edge();
                in_pix = stim_in[p];
                in_req = 1'b1;
                next_edge();
                while (!in_ack) next_edge();
                if (f > 0 && p == 0) begin    // store must hold off until frame 1 drained
                    assert (frame1_done) else stop_run("frame 2 accepted before frame 1 left");
                end
                in_req = 1'b0;
                next_edge();
                while (in_ack) next_edge();
            end
        end
    endtask

    task automatic receive_frames();
        logic [15:0] lfsr;
        int          cycles;
        rgb_t        held;
        logic        last;
        logic        border;
        lfsr = lfsr_seed;
        for (int f = 0; f < num_frames; f++) begin
            for (int p = 0; p < num_pix; p++) begin
                while (!out_req) next_edge();
                held   = out_pix;
                last   = out_last;
                border = p < img_dim || p >= num_pix - img_dim
                      || p % img_dim == 0 || p % img_dim == img_dim - 1;
                draw_wait(lfsr, cycles);
                repeat (cycles) begin
                    next_edge();
                    check_val("hold_pix", p, int'(held), int'(out_pix));
                    check_val("hold_last", p, int'(last), int'(out_last));
                end
                if (border) begin
                    check_val("border", p, int'(stim_in[p]), int'(held));
                end else begin
                    check_val("interior", p, int'(stim_exp[p]), int'(held));
                end
                check_val("last_flag", p, int'(p == num_pix - 1), int'(last));
                if (f == 0) begin
                    frame1[p] = held;
                end else begin
                    check_val("frame2_repeat", p, int'(frame1[p]), int'(held));
                end
                out_ack = 1'b1;
                next_edge();
                while (out_req) next_edge();
                if (p == num_pix - 1) begin
                    frame1_done = 1'b1;
                end
                out_ack = 1'b0;
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        in_req      = 1'b0;
        in_pix      = '0;
        out_ack     = 1'b0;
        frame1_done = 1'b0;
        error_count = 0;
        load_stim();
        repeat (2) @(posedge clk);
        #(drive_delay);
        rst = 1'b0;
        check_val("reset_in_ack", 0, 0, int'(in_ack));
        check_val("reset_out_req", 0, 0, int'(out_req));
        fork
            send_frames();
            receive_frames();
        join
        if (error_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1, "run ended with errors");
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        stop_run("timeout, the frames did not finish streaming in time");
    end

endmodule
